/* cmd_handler.sv */
//**************************************************************************
// command handler
// buffered commands to tag and data memory writes, with write timeout
//**************************************************************************

`timescale 1ns/10ps

module cmd_handler
  #(parameter sets_p = lce_pkg::default_sets
    , parameter ways_p = lce_pkg::default_ways
    , parameter addr_width_p = lce_pkg::default_addr_width
    , parameter block_width_p = lce_pkg::default_block_width
    , parameter timeout_limit_p = lce_pkg::default_timeout_limit
    , localparam index_width_lp = $clog2(sets_p)
    , localparam way_width_lp = $clog2(ways_p)
    , localparam offset_width_lp = $clog2(block_width_p/8)
    , localparam tag_width_lp = addr_width_p - index_width_lp - offset_width_lp
    , localparam timeout_width_lp = $clog2(timeout_limit_p+1)
   )
   (input                               clk_i
    , input                             reset_i

    // command head
    , input                             cmd_v_i
    , input lce_pkg::cmd_opcode_e       cmd_opcode_i
    , input [addr_width_p-1:0]          cmd_addr_i
    , input [way_width_lp-1:0]          cmd_way_i
    , output logic                      cmd_yumi_o

    // data command head
    , input                             data_cmd_v_i
    , input [addr_width_p-1:0]          data_cmd_addr_i
    , input [way_width_lp-1:0]          data_cmd_way_i
    , input [block_width_p-1:0]         data_cmd_data_i
    , output logic                      data_cmd_yumi_o

    , output logic                      tag_mem_pkt_v_o
    , output logic [index_width_lp-1:0] tag_mem_pkt_index_o
    , output logic [way_width_lp-1:0]   tag_mem_pkt_way_o
    , output logic [tag_width_lp-1:0]   tag_mem_pkt_tag_o
    , input                             tag_mem_pkt_yumi_i

    , output logic                      data_mem_pkt_v_o
    , output logic [index_width_lp-1:0] data_mem_pkt_index_o
    , output logic [way_width_lp-1:0]   data_mem_pkt_way_o
    , output logic [block_width_p-1:0]  data_mem_pkt_data_o
    , input                             data_mem_pkt_yumi_i

    , input                             cache_miss_i
    , output logic                      data_received_o
    , output logic                      tag_set_wakeup_o
    , output logic                      ready_o
   );

  import lce_pkg::*;

  logic [timeout_width_lp-1:0] timeout_cnt_r;
  logic [timeout_width_lp-1:0] timeout_cnt_n;
  logic timeout;
  logic pkt_v;
  logic pkt_yumi;

  // data command goes first
  assign data_mem_pkt_v_o     = data_cmd_v_i;
  assign data_mem_pkt_index_o = data_cmd_addr_i[offset_width_lp +: index_width_lp];
  assign data_mem_pkt_way_o   = data_cmd_way_i;
  assign data_mem_pkt_data_o  = data_cmd_data_i;

  // tag write held back behind a pending fill
  assign tag_mem_pkt_v_o     = cmd_v_i & ~data_cmd_v_i;
  assign tag_mem_pkt_index_o = cmd_addr_i[offset_width_lp +: index_width_lp];
  assign tag_mem_pkt_way_o   = cmd_way_i;
  assign tag_mem_pkt_tag_o   = cmd_addr_i[addr_width_p-1 -: tag_width_lp];

  assign data_cmd_yumi_o = data_mem_pkt_v_o & data_mem_pkt_yumi_i;
  assign cmd_yumi_o      = tag_mem_pkt_v_o & tag_mem_pkt_yumi_i;

  // one cycle completion pulses to the miss handler
  assign data_received_o  = data_cmd_yumi_o;
  assign tag_set_wakeup_o = cmd_yumi_o & (cmd_opcode_i == set_tag_wakeup);

  assign pkt_v    = data_mem_pkt_v_o | tag_mem_pkt_v_o;
  assign pkt_yumi = data_cmd_yumi_o | cmd_yumi_o;

  // count stalled write cycles
  always_comb begin
    timeout       = 1'b0;
    timeout_cnt_n = '0;
    if (timeout_cnt_r == timeout_limit_p) begin
      timeout = 1'b1;
    end else if (pkt_v & ~pkt_yumi) begin
      timeout_cnt_n = timeout_cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      timeout_cnt_r <= '0;
    else
      timeout_cnt_r <= timeout_cnt_n;
  end

  // low during a miss or the timeout cycle
  assign ready_o = ~cache_miss_i & ~timeout;

endmodule

/* lce_checker.sv */
//**************************************************************************
// protocol assertions on the lce packet and request ports
//**************************************************************************

`timescale 1ns/10ps

module lce_checker
  #(parameter addr_width_p = lce_pkg::default_addr_width
    , parameter tag_pkt_width_p = 32
    , parameter data_pkt_width_p = 73
   )
   (input                          clk_i
    , input                        reset_i
    , input                        tag_v_i
    , input [tag_pkt_width_p-1:0]  tag_pkt_i
    , input                        tag_yumi_i
    , input                        data_v_i
    , input [data_pkt_width_p-1:0] data_pkt_i
    , input                        data_yumi_i
    , input                        req_v_i
    , input [addr_width_p-1:0]     req_addr_i
    , input                        req_ready_i
   );

  // data first, so never both
  pkt_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(tag_v_i && data_v_i))
    else $error("tag and data packets valid in the same cycle");

  tag_pkt_held: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_v_i && !tag_yumi_i |=> $stable(tag_pkt_i))
    else $error("tag packet changed while held");

  data_pkt_held: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_i && !data_yumi_i |=> $stable(data_pkt_i))
    else $error("data packet changed while held");

  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && !req_ready_i |=> req_v_i && $stable(req_addr_i))
    else $error("request dropped or changed before ready");

  // consumer side may only pop a valid packet
  yumi_needs_v: assume property (@(posedge clk_i) disable iff (reset_i)
    (!tag_yumi_i || tag_v_i) && (!data_yumi_i || data_v_i))
    else $error("yumi high without a valid packet");

endmodule

bind lce_top lce_checker #(
  .addr_width_p      (addr_width_p)
  , .tag_pkt_width_p (index_width_lp + way_width_lp + tag_width_lp)
  , .data_pkt_width_p(index_width_lp + way_width_lp + block_width_p)
) chk (
  .clk_i       (clk_i)
  , .reset_i   (reset_i)
  , .tag_v_i   (tag_mem_pkt_v_o)
  , .tag_pkt_i ({tag_mem_pkt_index_o, tag_mem_pkt_way_o, tag_mem_pkt_tag_o})
  , .tag_yumi_i(tag_mem_pkt_yumi_i)
  , .data_v_i  (data_mem_pkt_v_o)
  , .data_pkt_i({data_mem_pkt_index_o, data_mem_pkt_way_o, data_mem_pkt_data_o})
  , .data_yumi_i(data_mem_pkt_yumi_i)
  , .req_v_i   (lce_req_v_o)
  , .req_addr_i(lce_req_addr_o)
  , .req_ready_i(lce_req_ready_i)
);

/* lce_pkg.sv */
//**************************************************************************
// lce shared definitions
// directory command opcodes and default cache geometry
//**************************************************************************

package lce_pkg;

  // directory command opcode
  typedef enum logic [0:0] {
    set_tag        = 1'b0,
    set_tag_wakeup = 1'b1
  } cmd_opcode_e;

  // default geometry
  localparam int default_sets        = 64;
  localparam int default_ways        = 8;

  // physical address and block size in bits
  localparam int default_addr_width  = 32;
  localparam int default_block_width = 64;

  // stalled write cycles before ready drops
  localparam int default_timeout_limit = 4;

endpackage

/* lce_top.sv */
//**************************************************************************
// icache lce miss and fill engine
// command buffers, miss handler and command handler
//**************************************************************************

`timescale 1ns/10ps

module lce_top
  #(parameter sets_p = lce_pkg::default_sets
    , parameter ways_p = lce_pkg::default_ways
    , parameter addr_width_p = lce_pkg::default_addr_width
    , parameter block_width_p = lce_pkg::default_block_width
    , parameter timeout_limit_p = lce_pkg::default_timeout_limit
    , localparam index_width_lp = $clog2(sets_p)
    , localparam way_width_lp = $clog2(ways_p)
    , localparam offset_width_lp = $clog2(block_width_p/8)
    , localparam tag_width_lp = addr_width_p - index_width_lp - offset_width_lp
   )
   (input                               clk_i
    , input                             reset_i

    , input                             miss_i
    , input [addr_width_p-1:0]          miss_addr_i
    , input [way_width_lp-1:0]          lru_way_i
    , output logic                      cache_miss_o
    , output logic                      ready_o

    , output logic                      lce_req_v_o
    , output logic [addr_width_p-1:0]   lce_req_addr_o
    , output logic [way_width_lp-1:0]   lce_req_way_o
    , input                             lce_req_ready_i

    , input                             lce_cmd_v_i
    , input lce_pkg::cmd_opcode_e       lce_cmd_opcode_i
    , input [addr_width_p-1:0]          lce_cmd_addr_i
    , input [way_width_lp-1:0]          lce_cmd_way_i
    , output logic                      lce_cmd_ready_o

    , input                             lce_data_cmd_v_i
    , input [addr_width_p-1:0]          lce_data_cmd_addr_i
    , input [way_width_lp-1:0]          lce_data_cmd_way_i
    , input [block_width_p-1:0]         lce_data_cmd_data_i
    , output logic                      lce_data_cmd_ready_o

    , output logic                      tag_mem_pkt_v_o
    , output logic [index_width_lp-1:0] tag_mem_pkt_index_o
    , output logic [way_width_lp-1:0]   tag_mem_pkt_way_o
    , output logic [tag_width_lp-1:0]   tag_mem_pkt_tag_o
    , input                             tag_mem_pkt_yumi_i

    , output logic                      data_mem_pkt_v_o
    , output logic [index_width_lp-1:0] data_mem_pkt_index_o
    , output logic [way_width_lp-1:0]   data_mem_pkt_way_o
    , output logic [block_width_p-1:0]  data_mem_pkt_data_o
    , input                             data_mem_pkt_yumi_i
   );

  import lce_pkg::*;

  localparam cmd_payload_width_lp = 1 + addr_width_p + way_width_lp;
  localparam data_payload_width_lp = addr_width_p + way_width_lp + block_width_p;

  typedef logic [cmd_payload_width_lp-1:0] cmd_payload_t;
  typedef logic [data_payload_width_lp-1:0] data_payload_t;

  // {opcode, addr, way}
  cmd_payload_t cmd_fifo_data_li;
  cmd_payload_t cmd_fifo_data_lo;
  logic         cmd_fifo_v_lo;
  logic         cmd_fifo_yumi_li;

  // {addr, way, data}
  data_payload_t data_cmd_fifo_data_li;
  data_payload_t data_cmd_fifo_data_lo;
  logic          data_cmd_fifo_v_lo;
  logic          data_cmd_fifo_yumi_li;

  cmd_opcode_e              cmd_head_opcode;
  logic [addr_width_p-1:0]  cmd_head_addr;
  logic [way_width_lp-1:0]  cmd_head_way;
  logic [addr_width_p-1:0]  data_cmd_head_addr;
  logic [way_width_lp-1:0]  data_cmd_head_way;
  logic [block_width_p-1:0] data_cmd_head_data;

  logic data_received_lo;
  logic tag_set_wakeup_lo;

  assign cmd_fifo_data_li = {lce_cmd_opcode_i, lce_cmd_addr_i, lce_cmd_way_i};
  assign data_cmd_fifo_data_li = {lce_data_cmd_addr_i, lce_data_cmd_way_i, lce_data_cmd_data_i};

  assign cmd_head_opcode = cmd_opcode_e'(cmd_fifo_data_lo[cmd_payload_width_lp-1]);
  assign cmd_head_addr   = cmd_fifo_data_lo[way_width_lp +: addr_width_p];
  assign cmd_head_way    = cmd_fifo_data_lo[way_width_lp-1:0];

  assign data_cmd_head_addr = data_cmd_fifo_data_lo[data_payload_width_lp-1 -: addr_width_p];
  assign data_cmd_head_way  = data_cmd_fifo_data_lo[block_width_p +: way_width_lp];
  assign data_cmd_head_data = data_cmd_fifo_data_lo[block_width_p-1:0];

  two_entry_fifo #(.payload_t(cmd_payload_t)) cmd_fifo (
    .clk_i    (clk_i)
    , .reset_i(reset_i)
    , .v_i    (lce_cmd_v_i)
    , .data_i (cmd_fifo_data_li)
    , .ready_o(lce_cmd_ready_o)
    , .v_o    (cmd_fifo_v_lo)
    , .data_o (cmd_fifo_data_lo)
    , .yumi_i (cmd_fifo_yumi_li)
  );

  two_entry_fifo #(.payload_t(data_payload_t)) data_cmd_fifo (
    .clk_i    (clk_i)
    , .reset_i(reset_i)
    , .v_i    (lce_data_cmd_v_i)
    , .data_i (data_cmd_fifo_data_li)
    , .ready_o(lce_data_cmd_ready_o)
    , .v_o    (data_cmd_fifo_v_lo)
    , .data_o (data_cmd_fifo_data_lo)
    , .yumi_i (data_cmd_fifo_yumi_li)
  );

  miss_handler #(
    .sets_p         (sets_p)
    , .ways_p       (ways_p)
    , .addr_width_p (addr_width_p)
    , .block_width_p(block_width_p)
  ) miss (
    .clk_i             (clk_i)
    , .reset_i         (reset_i)
    , .miss_i          (miss_i)
    , .miss_addr_i     (miss_addr_i)
    , .lru_way_i       (lru_way_i)
    , .cache_miss_o    (cache_miss_o)
    , .lce_req_v_o     (lce_req_v_o)
    , .lce_req_addr_o  (lce_req_addr_o)
    , .lce_req_way_o   (lce_req_way_o)
    , .lce_req_ready_i (lce_req_ready_i)
    , .data_received_i (data_received_lo)
    , .tag_set_wakeup_i(tag_set_wakeup_lo)
  );

  cmd_handler #(
    .sets_p           (sets_p)
    , .ways_p         (ways_p)
    , .addr_width_p   (addr_width_p)
    , .block_width_p  (block_width_p)
    , .timeout_limit_p(timeout_limit_p)
  ) cmd (
    .clk_i                 (clk_i)
    , .reset_i             (reset_i)
    , .cmd_v_i             (cmd_fifo_v_lo)
    , .cmd_opcode_i        (cmd_head_opcode)
    , .cmd_addr_i          (cmd_head_addr)
    , .cmd_way_i           (cmd_head_way)
    , .cmd_yumi_o          (cmd_fifo_yumi_li)
    , .data_cmd_v_i        (data_cmd_fifo_v_lo)
    , .data_cmd_addr_i     (data_cmd_head_addr)
    , .data_cmd_way_i      (data_cmd_head_way)
    , .data_cmd_data_i     (data_cmd_head_data)
    , .data_cmd_yumi_o     (data_cmd_fifo_yumi_li)
    , .tag_mem_pkt_v_o     (tag_mem_pkt_v_o)
    , .tag_mem_pkt_index_o (tag_mem_pkt_index_o)
    , .tag_mem_pkt_way_o   (tag_mem_pkt_way_o)
    , .tag_mem_pkt_tag_o   (tag_mem_pkt_tag_o)
    , .tag_mem_pkt_yumi_i  (tag_mem_pkt_yumi_i)
    , .data_mem_pkt_v_o    (data_mem_pkt_v_o)
    , .data_mem_pkt_index_o(data_mem_pkt_index_o)
    , .data_mem_pkt_way_o  (data_mem_pkt_way_o)
    , .data_mem_pkt_data_o (data_mem_pkt_data_o)
    , .data_mem_pkt_yumi_i (data_mem_pkt_yumi_i)
    , .cache_miss_i        (cache_miss_o)
    , .data_received_o     (data_received_lo)
    , .tag_set_wakeup_o    (tag_set_wakeup_lo)
    , .ready_o             (ready_o)
  );

endmodule

/* miss_handler.sv */
//**************************************************************************
// miss handler
// captures a miss, sends the directory request, waits for fill and tag
//**************************************************************************

`timescale 1ns/10ps

module miss_handler
  #(parameter sets_p = lce_pkg::default_sets
    , parameter ways_p = lce_pkg::default_ways
    , parameter addr_width_p = lce_pkg::default_addr_width
    , parameter block_width_p = lce_pkg::default_block_width
    , localparam index_width_lp = $clog2(sets_p)
    , localparam way_width_lp = $clog2(ways_p)
    , localparam offset_width_lp = $clog2(block_width_p/8)
    , localparam tag_width_lp = addr_width_p - index_width_lp - offset_width_lp
   )
   (input                             clk_i
    , input                           reset_i

    , input                           miss_i
    , input [addr_width_p-1:0]        miss_addr_i
    , input [way_width_lp-1:0]        lru_way_i
    , output logic                    cache_miss_o

    , output logic                    lce_req_v_o
    , output logic [addr_width_p-1:0] lce_req_addr_o
    , output logic [way_width_lp-1:0] lce_req_way_o
    , input                           lce_req_ready_i

    , input                           data_received_i
    , input                           tag_set_wakeup_i
   );

  typedef enum logic [1:0] {
    idle_s,
    send_req_s,
    wait_s
  } state_e;

  state_e state_r;
  state_e state_n;

  logic [tag_width_lp-1:0]   miss_tag;
  logic [index_width_lp-1:0] miss_index;
  logic [addr_width_p-1:0]   addr_r;
  logic [way_width_lp-1:0]   way_r;

  logic data_seen_r;
  logic wakeup_seen_r;
  logic data_done;
  logic wakeup_done;
  logic fill_done;
  logic miss_accept;

  assign miss_tag   = miss_addr_i[addr_width_p-1 -: tag_width_lp];
  assign miss_index = miss_addr_i[offset_width_lp +: index_width_lp];

  assign miss_accept = (state_r == idle_s) & miss_i;

  // completion events may come in either order
  assign data_done   = data_seen_r | data_received_i;
  assign wakeup_done = wakeup_seen_r | tag_set_wakeup_i;
  assign fill_done   = data_done & wakeup_done;

  always_comb begin
    state_n = state_r;
    case (state_r)
      idle_s:
        if (miss_i)
          state_n = send_req_s;
      send_req_s:
        if (lce_req_ready_i)
          state_n = fill_done ? idle_s : wait_s;
      wait_s:
        if (fill_done)
          state_n = idle_s;
      default:
        state_n = idle_s;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r       <= idle_s;
      data_seen_r   <= 1'b0;
      wakeup_seen_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (state_r == idle_s) begin
        data_seen_r   <= 1'b0;
        wakeup_seen_r <= 1'b0;
      end else begin
        data_seen_r   <= data_done;
        wakeup_seen_r <= wakeup_done;
      end
    end
  end

  // block aligned request address
  always_ff @(posedge clk_i) begin
    if (miss_accept) begin
      addr_r <= {miss_tag, miss_index, {offset_width_lp{1'b0}}};
      way_r  <= lru_way_i;
    end
  end

  assign cache_miss_o   = (state_r != idle_s);
  assign lce_req_v_o    = (state_r == send_req_s);
  assign lce_req_addr_o = addr_r;
  assign lce_req_way_o  = way_r;

endmodule

/* src.f */
lce_pkg.sv
two_entry_fifo.sv
miss_handler.sv
cmd_handler.sv
lce_top.sv
lce_checker.sv
tb_lce_top.sv

/* tb_lce_top.sv */
//**************************************************************************
// testbench for the lce miss and fill engine
// table driven rows of misses, commands, data fills and stalls
//**************************************************************************

`timescale 1ns/10ps

module tb_lce_top;

  import lce_pkg::*;

  localparam int off_w      = $clog2(default_block_width/8);
  localparam int idx_w      = $clog2(default_sets);
  localparam int n_rows     = 11;
  localparam int max_cycles = 40*n_rows + 100;

  typedef enum {row_miss, row_cmd, row_data, row_stall} row_kind_e;

  logic        clk_i;
  logic        reset_i;
  logic        miss_i;
  logic [31:0] miss_addr_i;
  logic [2:0]  lru_way_i;
  logic        cache_miss_o;
  logic        ready_o;
  logic        lce_req_v_o;
  logic [31:0] lce_req_addr_o;
  logic [2:0]  lce_req_way_o;
  logic        lce_req_ready_i;
  logic        lce_cmd_v_i;
  cmd_opcode_e lce_cmd_opcode_i;
  logic [31:0] lce_cmd_addr_i;
  logic [2:0]  lce_cmd_way_i;
  logic        lce_cmd_ready_o;
  logic        lce_data_cmd_v_i;
  logic [31:0] lce_data_cmd_addr_i;
  logic [2:0]  lce_data_cmd_way_i;
  logic [63:0] lce_data_cmd_data_i;
  logic        lce_data_cmd_ready_o;
  logic        tag_mem_pkt_v_o;
  logic [5:0]  tag_mem_pkt_index_o;
  logic [2:0]  tag_mem_pkt_way_o;
  logic [22:0] tag_mem_pkt_tag_o;
  logic        tag_mem_pkt_yumi_i;
  logic        data_mem_pkt_v_o;
  logic [5:0]  data_mem_pkt_index_o;
  logic [2:0]  data_mem_pkt_way_o;
  logic [63:0] data_mem_pkt_data_o;
  logic        data_mem_pkt_yumi_i;

  // stimulus table with seeded addresses and data
  row_kind_e kind [n_rows] = '{row_miss, row_cmd, row_data, row_cmd, row_miss, row_cmd,
                               row_data, row_stall, row_miss, row_data, row_cmd};
  cmd_opcode_e op [n_rows] = '{set_tag, set_tag, set_tag, set_tag_wakeup, set_tag,
                               set_tag_wakeup, set_tag, set_tag, set_tag, set_tag,
                               set_tag_wakeup};
  logic [31:0] addr [n_rows];
  logic [2:0]  way [n_rows];
  logic [63:0] data [n_rows];
  logic [31:0] exp_aligned [n_rows];
  logic [5:0]  exp_index [n_rows];
  logic [22:0] exp_tag [n_rows];

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  // expected miss state
  bit pend;
  bit data_seen;
  bit wake_seen;

  lce_top dut (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == max_cycles) begin
      $display("run stopped after %0d cycles before the table was done", cycles);
      $display("checks %0d errors %0d", checks, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic cycle();
    @(posedge clk_i);
    #2;
  endtask

  function automatic void check_value(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
    end
  endfunction

  task automatic send_cmd(int i, cmd_opcode_e o, logic [2:0] w);
    check_value("lce_cmd_ready_o", 1, lce_cmd_ready_o);
    lce_cmd_v_i      = 1'b1;
    lce_cmd_opcode_i = o;
    lce_cmd_addr_i   = addr[i];
    lce_cmd_way_i    = w;
  endtask

  task automatic send_data(int i);
    check_value("lce_data_cmd_ready_o", 1, lce_data_cmd_ready_o);
    lce_data_cmd_v_i    = 1'b1;
    lce_data_cmd_addr_i = addr[i];
    lce_data_cmd_way_i  = way[i];
    lce_data_cmd_data_i = data[i];
  endtask

  task automatic pop_tag(int i, logic [2:0] w);
    while (!tag_mem_pkt_v_o)
      cycle();
    // packet waits one cycle before the pop
    cycle();
    check_value("tag_mem_pkt_v_o", 1, tag_mem_pkt_v_o);
    check_value("tag_mem_pkt_index_o", exp_index[i], tag_mem_pkt_index_o);
    check_value("tag_mem_pkt_way_o", w, tag_mem_pkt_way_o);
    check_value("tag_mem_pkt_tag_o", exp_tag[i], tag_mem_pkt_tag_o);
    tag_mem_pkt_yumi_i = 1'b1;
    cycle();
    tag_mem_pkt_yumi_i = 1'b0;
  endtask

  task automatic pop_data(int i);
    while (!data_mem_pkt_v_o)
      cycle();
    check_value("data_mem_pkt_index_o", exp_index[i], data_mem_pkt_index_o);
    check_value("data_mem_pkt_way_o", way[i], data_mem_pkt_way_o);
    check_value("data_mem_pkt_data_o", data[i], data_mem_pkt_data_o);
    data_mem_pkt_yumi_i = 1'b1;
    cycle();
    data_mem_pkt_yumi_i = 1'b0;
  endtask

  // miss ends only after both fill and wakeup
  task automatic check_miss_state();
    if (pend && data_seen && wake_seen)
      pend = 1'b0;
    check_value("cache_miss_o", pend, cache_miss_o);
    check_value("ready_o", !pend, ready_o);
  endtask

  task automatic run_miss(int i);
    miss_i      = 1'b1;
    miss_addr_i = addr[i];
    lru_way_i   = way[i];
    cycle();
    miss_addr_i = ~addr[i];
    lru_way_i   = ~way[i];
    // directory holds off the request while a second miss pulse comes in
    for (int k = 0; k < 4; k++) begin
      check_value("lce_req_v_o", 1, lce_req_v_o);
      check_value("lce_req_addr_o", exp_aligned[i], lce_req_addr_o);
      check_value("lce_req_way_o", way[i], lce_req_way_o);
      check_value("cache_miss_o", 1, cache_miss_o);
      check_value("ready_o", 0, ready_o);
      miss_i          = (k == 1);
      lce_req_ready_i = (k == 3);
      cycle();
    end
    lce_req_ready_i = 1'b0;
    pend            = 1'b1;
    data_seen       = 1'b0;
    wake_seen       = 1'b0;
    check_value("lce_req_v_o", 0, lce_req_v_o);
    check_miss_state();
    cycle();
    check_value("lce_req_v_o", 0, lce_req_v_o);
  endtask

  task automatic run_cmd(int i);
    send_cmd(i, op[i], way[i]);
    cycle();
    lce_cmd_v_i = 1'b0;
    pop_tag(i, way[i]);
    if (pend && op[i] == set_tag_wakeup)
      wake_seen = 1'b1;
    check_miss_state();
  endtask

  task automatic run_data(int i);
    send_data(i);
    cycle();
    lce_data_cmd_v_i = 1'b0;
    pop_data(i);
    if (pend)
      data_seen = 1'b1;
    check_miss_state();
  endtask

  task automatic run_stall(int i);
    int cnt;
    send_cmd(i, set_tag, way[i]);
    send_data(i);
    cycle();
    send_cmd(i, set_tag, way[i] + 3'd1);
    lce_data_cmd_v_i = 1'b0;
    cnt = 0;
    // ready drops once per timeout period while the data packet is held
    for (int k = 0; k < 12; k++) begin
      check_value("data_mem_pkt_v_o", 1, data_mem_pkt_v_o);
      check_value("tag_mem_pkt_v_o", 0, tag_mem_pkt_v_o);
      check_value("ready_o", !pend && cnt != default_timeout_limit, ready_o);
      if (k > 0)
        check_value("lce_cmd_ready_o", 0, lce_cmd_ready_o);
      cnt = (cnt == default_timeout_limit) ? 0 : cnt + 1;
      cycle();
      lce_cmd_v_i = 1'b0;
    end
    pop_data(i);
    check_value("tag_mem_pkt_v_o", 1, tag_mem_pkt_v_o);
    pop_tag(i, way[i]);
    pop_tag(i, way[i] + 3'd1);
  endtask

  initial begin
    void'($urandom(79036));
    clk_i               = 1'b0;
    reset_i             = 1'b1;
    miss_i              = 1'b0;
    miss_addr_i         = '0;
    lru_way_i           = '0;
    lce_req_ready_i     = 1'b0;
    lce_cmd_v_i         = 1'b0;
    lce_cmd_opcode_i    = set_tag;
    lce_cmd_addr_i      = '0;
    lce_cmd_way_i       = '0;
    lce_data_cmd_v_i    = 1'b0;
    lce_data_cmd_addr_i = '0;
    lce_data_cmd_way_i  = '0;
    lce_data_cmd_data_i = '0;
    tag_mem_pkt_yumi_i  = 1'b0;
    data_mem_pkt_yumi_i = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      addr[i]        = $urandom;
      way[i]         = 3'($urandom);
      data[i]        = {$urandom, $urandom};
      exp_aligned[i] = {addr[i][31:off_w], {off_w{1'b0}}};
      exp_index[i]   = addr[i][off_w +: idx_w];
      exp_tag[i]     = addr[i][31:off_w+idx_w];
    end
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    check_value("cache_miss_o", 0, cache_miss_o);
    check_value("lce_req_v_o", 0, lce_req_v_o);
    check_value("ready_o", 1, ready_o);
    check_value("tag_mem_pkt_v_o", 0, tag_mem_pkt_v_o);
    check_value("data_mem_pkt_v_o", 0, data_mem_pkt_v_o);
    for (int i = 0; i < n_rows; i++) begin
      case (kind[i])
        row_miss: run_miss(i);
        row_cmd:  run_cmd(i);
        row_data: run_data(i);
        default:  run_stall(i);
      endcase
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* two_entry_fifo.sv */
//**************************************************************************
// two entry buffer
// valid/ready on the input side, valid/yumi on the output side
//**************************************************************************

`timescale 1ns/10ps

module two_entry_fifo
  #(parameter type payload_t = logic)
  (input              clk_i
   , input            reset_i

   , input            v_i
   , input  payload_t data_i
   , output logic     ready_o

   , output logic     v_o
   , output payload_t data_o
   , input            yumi_i
  );

  payload_t mem_r [2];

  logic rd_ptr_r;
  logic wr_ptr_r;
  logic full_r;
  logic empty;
  logic enq;
  logic deq;

  // pointers equal means empty unless the full flag is set
  assign empty   = (rd_ptr_r == wr_ptr_r) & ~full_r;
  assign ready_o = ~full_r;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end else begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      // second entry lands on an occupied buffer
      if (enq & ~deq)
        full_r <= (wr_ptr_r != rd_ptr_r);
      else if (deq & ~enq)
        full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule
